//--- src.f
+incdir+.
tti_queue_pkg.sv
tti_csr_pkg.sv
tti_csr_port.sv
tti_queue.sv
tti_irq_status.sv
tti.sv
tb_clock.sv
tti_sva.sv
tti_tb.sv

//--- Makefile
# Verilator build and run for the transaction interface testbench

VERILATOR   ?= verilator
TOP         ?= tti_tb
FILELIST    ?= src.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --binary --timing --assert -Wall
LINT_FLAGS  ?= --lint-only --timing --assert -Wall
PASS_STRING ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STRING)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tti_tb.sv
`timescale 1ns/1ps
/* Queue order 0 rx_desc, 1 rx_data, 2 tx_desc, 3 tx_data, 4 ibi.
   Clear steps carry the enable vector in bits 25:16 and the W1C mask in bits 9:0 */
`include "tti_settings.svh"

module tti_tb;

  typedef enum int {BUS_WR, CSR_WR, CSR_RD, BUS_POP, SET_THLD, SOFT_RST, CLR_STAT} op_e;

  typedef struct {
    string       name;
    op_e         op;
    int          q;
    logic [31:0] arg;
  } step_t;

  localparam int Depth [5] = '{`TTI_DESC_DEPTH, `TTI_DATA_DEPTH, `TTI_DESC_DEPTH,
                              `TTI_DATA_DEPTH, `TTI_IBI_DEPTH};

  logic                      clk;
  logic                      rst_n;
  tti_csr_pkg::csr_tti_out_t csr;
  tti_csr_pkg::csr_tti_in_t  csr_out;
  logic                      rx_desc_wvalid, rx_data_wvalid;
  tti_queue_pkg::rx_desc_t   rx_desc_wdata;
  tti_queue_pkg::data_word_t rx_data_wdata;
  logic                      rx_desc_wready, rx_data_wready;
  logic                      tx_desc_rvalid, tx_data_rvalid, ibi_rvalid;
  logic                      tx_desc_rready, tx_data_rready, ibi_rready;
  tti_queue_pkg::tx_desc_t   tx_desc_rdata;
  tti_queue_pkg::data_word_t tx_data_rdata, ibi_rdata;

  step_t                  steps[$];
  logic [31:0]            model [5][$];
  logic [`TTI_THLD_W-1:0] thld_eff [5];
  logic [4:0]             prev_trig;
  logic [`TTI_IRQ_N-1:0]  exp_status;
  logic [`TTI_IRQ_N-1:0]  enable;
  logic [31:0]            lfsr;
  int                     cycles;
  int                     limit;

  tb_clock #(.ResetCycles(5)) u_clock (.clk_o(clk), .rst_no(rst_n));

  tti UUT (
    .clk_i(clk), .rst_ni(rst_n), .csr_i(csr), .csr_o(csr_out),
    .rx_desc_wvalid_i(rx_desc_wvalid), .rx_desc_wdata_i(rx_desc_wdata),
    .rx_desc_wready_o(rx_desc_wready), .rx_data_wvalid_i(rx_data_wvalid),
    .rx_data_wdata_i(rx_data_wdata), .rx_data_wready_o(rx_data_wready),
    .tx_desc_rvalid_o(tx_desc_rvalid), .tx_desc_rready_i(tx_desc_rready),
    .tx_desc_rdata_o(tx_desc_rdata), .tx_data_rvalid_o(tx_data_rvalid),
    .tx_data_rready_i(tx_data_rready), .tx_data_rdata_o(tx_data_rdata),
    .ibi_rvalid_o(ibi_rvalid), .ibi_rready_i(ibi_rready), .ibi_rdata_o(ibi_rdata)
  );

  task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("ERR %s: expected %h, actual %h", name, exp, act);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_rx_desc(input string name, input tti_queue_pkg::rx_desc_t exp,
                               input tti_queue_pkg::rx_desc_t act);
    if (exp !== act) fail_value(name, exp, act);
  endtask

  task automatic check_tx_desc(input string name, input tti_queue_pkg::tx_desc_t exp,
                               input tti_queue_pkg::tx_desc_t act);
    if (exp !== act) fail_value(name, exp, act);
  endtask

  task automatic check_word(input string name, input tti_queue_pkg::data_word_t exp,
                            input tti_queue_pkg::data_word_t act);
    if (exp !== act) fail_value(name, exp, act);
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) fail_value(name, 32'(exp), 32'(act));
  endtask

  task automatic check_thld(input string name, input logic [`TTI_THLD_W-1:0] exp,
                            input logic [`TTI_THLD_W-1:0] act);
    if (exp !== act) fail_value(name, 32'(exp), 32'(act));
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    logic        b;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      b    = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
      w    = {w[30:0], b};
    end
    return w;
  endfunction

  function automatic tti_queue_pkg::queue_stat_t get_stat(input int q);
    case (q)
      0: return csr_out.rx_desc_stat;
      1: return csr_out.rx_data_stat;
      2: return csr_out.tx_desc_stat;
      3: return csr_out.tx_data_stat;
      default: return csr_out.ibi_stat;
    endcase
  endfunction

  function automatic logic exp_trig(input int q);
    int n;
    n = model[q].size();
    if (thld_eff[q] == '0) return 1'b0;
    return (q < 2) ? (n >= int'(thld_eff[q])) : (Depth[q] - n >= int'(thld_eff[q]));
  endfunction

  task automatic drive_port(input int q, input logic req, input logic is_wr,
                            input logic [31:0] data);
    case (q)
      0: csr.rx_desc_port <= '{req: req, req_is_wr: is_wr, wr_data: data};
      1: csr.rx_data_port <= '{req: req, req_is_wr: is_wr, wr_data: data};
      2: csr.tx_desc_port <= '{req: req, req_is_wr: is_wr, wr_data: data};
      3: csr.tx_data_port <= '{req: req, req_is_wr: is_wr, wr_data: data};
      default: csr.ibi_port <= '{req: req, req_is_wr: is_wr, wr_data: data};
    endcase
  endtask

  task automatic drive_thld(input int q, input logic [`TTI_THLD_W-1:0] v, input logic sw);
    case (q)
      0: csr.rx_desc_thld <= '{value: v, swmod: sw};
      1: csr.rx_data_thld <= '{value: v, swmod: sw};
      2: csr.tx_desc_thld <= '{value: v, swmod: sw};
      3: csr.tx_data_thld <= '{value: v, swmod: sw};
      default: csr.ibi_thld <= '{value: v, swmod: sw};
    endcase
  endtask

  task automatic drive_rst(input int q, input logic v);
    case (q)
      0: csr.rx_desc_rst <= v;
      1: csr.rx_data_rst <= v;
      2: csr.tx_desc_rst <= v;
      3: csr.tx_data_rst <= v;
      default: csr.ibi_rst <= v;
    endcase
  endtask

  task automatic check_head(input string name, input int q);
    case (q)
      2: begin
        check_flag({name, ".rvalid"}, 1'b1, tx_desc_rvalid);
        check_tx_desc({name, ".rdata"}, model[2][0], tx_desc_rdata);
      end
      3: begin
        check_flag({name, ".rvalid"}, 1'b1, tx_data_rvalid);
        check_word({name, ".rdata"}, model[3][0], tx_data_rdata);
      end
      default: begin
        check_flag({name, ".rvalid"}, 1'b1, ibi_rvalid);
        check_word({name, ".rdata"}, model[4][0], ibi_rdata);
      end
    endcase
  endtask

  // Queue levels, triggers, thresholds, status and irq after settling
  task automatic check_all(input string name);
    tti_queue_pkg::queue_stat_t s;
    logic                       t;
    for (int q = 0; q < 5; q++) begin
      s = get_stat(q);
      t = exp_trig(q);
      if (t && !prev_trig[q]) exp_status[2*q] = 1'b1;
      prev_trig[q] = t;
      check_flag($sformatf("%s.q%0d.full", name, q), model[q].size() == Depth[q], s.full);
      check_flag($sformatf("%s.q%0d.empty", name, q), model[q].size() == 0, s.empty);
      check_flag($sformatf("%s.q%0d.trig", name, q), t, s.ready_trig);
      check_thld($sformatf("%s.q%0d.thld", name, q), thld_eff[q], s.ready_thld_eff);
    end
    check_flag({name, ".wready0"}, model[0].size() < Depth[0], rx_desc_wready);
    check_flag({name, ".wready1"}, model[1].size() < Depth[1], rx_data_wready);
    check_word({name, ".status"}, 32'(exp_status), 32'(csr_out.irq_status));
    check_flag({name, ".irq"}, |(exp_status & enable), csr_out.irq);
  endtask

  task automatic run_step(input step_t st);
    logic [31:0]                d;
    tti_queue_pkg::queue_stat_t s;
    int                         pulses;
    logic                       room;
    case (st.op)
      BUS_WR: begin
        d = rand_word();
        @(posedge clk);
        if (st.q == 0) begin
          rx_desc_wvalid <= 1'b1;
          rx_desc_wdata  <= d;
        end else begin
          rx_data_wvalid <= 1'b1;
          rx_data_wdata  <= d;
        end
        @(negedge clk);
        room = model[st.q].size() < Depth[st.q];
        check_flag({st.name, ".wready"}, room, st.q == 0 ? rx_desc_wready : rx_data_wready);
        @(posedge clk);
        rx_desc_wvalid <= 1'b0;
        rx_data_wvalid <= 1'b0;
        if (room) model[st.q].push_back(d);
      end
      CSR_WR, CSR_RD: begin
        d = (st.op == CSR_WR) ? rand_word() : 32'h0;
        @(posedge clk);
        drive_port(st.q, 1'b1, st.op == CSR_WR, d);
        @(negedge clk);
        check_flag({st.name, ".ack_early"}, 1'b0, get_stat(st.q).ack);
        @(posedge clk);
        drive_port(st.q, 1'b0, 1'b0, 32'h0);
        @(negedge clk);
        s = get_stat(st.q);
        check_flag({st.name, ".ack"}, 1'b1, s.ack);
        if (st.op == CSR_WR) begin
          room = model[st.q].size() < Depth[st.q];
          check_flag({st.name, ".overflow"}, !room, s.overflow);
          if (room) model[st.q].push_back(d);
          else exp_status[2*st.q+1] = 1'b1;
          check_head(st.name, st.q);
        end else begin
          check_flag({st.name, ".underflow"}, model[st.q].size() == 0, s.underflow);
          if (model[st.q].size() == 0) begin
            check_word({st.name, ".rd_data"}, 32'h0, s.rd_data);
            exp_status[2*st.q+1] = 1'b1;
          end else if (st.q == 0) begin
            check_rx_desc({st.name, ".rd_data"}, model[0].pop_front(), s.rd_data);
          end else begin
            check_word({st.name, ".rd_data"}, model[1].pop_front(), s.rd_data);
          end
        end
        @(negedge clk);
        check_flag({st.name, ".ack_late"}, 1'b0, get_stat(st.q).ack);
      end
      BUS_POP: begin
        @(negedge clk);
        check_head(st.name, st.q);
        @(negedge clk);
        check_head({st.name, ".hold"}, st.q);  // rready still low
        @(posedge clk);
        tx_desc_rready <= (st.q == 2);
        tx_data_rready <= (st.q == 3);
        ibi_rready     <= (st.q == 4);
        @(posedge clk);
        tx_desc_rready <= 1'b0;
        tx_data_rready <= 1'b0;
        ibi_rready     <= 1'b0;
        void'(model[st.q].pop_front());
      end
      SET_THLD: begin
        @(posedge clk);
        drive_thld(st.q, st.arg[`TTI_THLD_W-1:0], 1'b1);
        @(posedge clk);
        drive_thld(st.q, st.arg[`TTI_THLD_W-1:0], 1'b0);
        repeat (3) @(posedge clk);
        thld_eff[st.q] = (st.arg > Depth[st.q]) ? `TTI_THLD_W'(Depth[st.q])
                                                : st.arg[`TTI_THLD_W-1:0];
      end
      SOFT_RST: begin
        pulses = 0;
        @(posedge clk);
        drive_rst(st.q, 1'b1);
        for (int i = 0; i < 4; i++) begin
          @(negedge clk);
          if (get_stat(st.q).rst_clr_we) pulses++;
          @(posedge clk);
          if (i == 1) drive_rst(st.q, 1'b0);
        end
        check_word({st.name, ".clr_pulses"}, 32'd1, pulses);
        model[st.q].delete();
      end
      default: begin
        @(posedge clk);
        csr.irq_w1c    <= st.arg[`TTI_IRQ_N-1:0];
        csr.irq_enable <= st.arg[16 +: `TTI_IRQ_N];
        @(posedge clk);
        csr.irq_w1c <= '0;
        exp_status = exp_status & ~st.arg[`TTI_IRQ_N-1:0];
        enable     = st.arg[16 +: `TTI_IRQ_N];
      end
    endcase
    repeat (3) @(negedge clk);
    check_all(st.name);
  endtask

  task automatic add(input string name, input op_e op, input int q, input logic [31:0] arg);
    steps.push_back('{name: name, op: op, q: q, arg: arg});
  endtask

  task automatic build_table();
    for (int i = 0; i < 3; i++) add($sformatf("rx_desc_wr%0d", i), BUS_WR, 0, 0);
    for (int i = 0; i < 2; i++) add($sformatf("rx_data_wr%0d", i), BUS_WR, 1, 0);
    for (int i = 0; i < 3; i++) add($sformatf("rx_desc_rd%0d", i), CSR_RD, 0, 0);
    for (int i = 0; i < 2; i++) add($sformatf("rx_data_rd%0d", i), CSR_RD, 1, 0);
    for (int q = 2; q < 5; q++) begin
      add($sformatf("csr_wr_a_q%0d", q), CSR_WR, q, 0);
      add($sformatf("csr_wr_b_q%0d", q), CSR_WR, q, 0);
    end
    for (int q = 2; q < 5; q++) begin
      add($sformatf("pop_a_q%0d", q), BUS_POP, q, 0);
      add($sformatf("pop_b_q%0d", q), BUS_POP, q, 0);
    end
    for (int i = 0; i < 5; i++) add($sformatf("ibi_fill%0d", i), CSR_WR, 4, 0);
    for (int i = 0; i < 9; i++) add($sformatf("rx_desc_fill%0d", i), BUS_WR, 0, 0);
    add("rx_data_empty_rd", CSR_RD, 1, 0);
    add("irq_masked", CLR_STAT, 0, 32'h0);
    add("thld_rx_desc", SET_THLD, 0, 3);
    add("thld_ibi_clamp", SET_THLD, 4, 31);
    add("thld_tx_desc", SET_THLD, 2, 2);
    add("irq_enable", CLR_STAT, 0, 32'h03ff_0000);
    add("irq_clear", CLR_STAT, 0, 32'h03ff_03ff);
    add("ibi_soft_rst", SOFT_RST, 4, 0);
    add("rx_desc_soft_rst", SOFT_RST, 0, 0);
    for (int i = 0; i < 3; i++) add($sformatf("rx_desc_refill%0d", i), BUS_WR, 0, 0);
    add("rx_desc_after_rst_rd", CSR_RD, 0, 0);
    add("ibi_after_rst_wr", CSR_WR, 4, 0);
    add("ibi_after_rst_pop", BUS_POP, 4, 0);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  initial begin
    csr            = '0;
    rx_desc_wvalid = 1'b0;
    rx_desc_wdata  = '0;
    rx_data_wvalid = 1'b0;
    rx_data_wdata  = '0;
    tx_desc_rready = 1'b0;
    tx_data_rready = 1'b0;
    ibi_rready     = 1'b0;
    lfsr           = 32'h69a6;
    cycles         = 0;
    limit          = 0;
    prev_trig      = '0;
    exp_status     = '0;
    enable         = '0;
    for (int q = 0; q < 5; q++) thld_eff[q] = '0;
    build_table();
    limit = 20 * steps.size();
    wait (rst_n);
    @(negedge clk);
    check_all("reset");
    foreach (steps[i]) run_step(steps[i]);
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- tti_sva.sv
`timescale 1ns/1ps
/* Bound into every tti_queue. Back-to-back CSR requests are allowed by the ack check */

module tti_sva (
  input logic                       clk_i,
  input logic                       rst_ni,
  input tti_queue_pkg::queue_ctrl_t ctrl_i,
  input tti_queue_pkg::queue_stat_t stat_o,
  input logic                       bus_valid_i,
  input logic                       bus_valid_o
);

  // Ack answers a request one cycle later
  ack_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl_i.req |=> stat_o.ack)
    else $error("ack missing after request");

  ack_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stat_o.ack |-> $past(ctrl_i.req))
    else $error("ack without a request");

  ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stat_o.ack |=> (!stat_o.ack || $past(ctrl_i.req)))
    else $error("ack longer than one cycle");

  // Valid only leaves the empty state through a write
  rvalid_after_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(bus_valid_o) |-> ($past(ctrl_i.req | bus_valid_i) && !$past(ctrl_i.soft_rst)))
    else $error("rvalid rose without a write");

  rst_clr_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stat_o.rst_clr_we |=> !stat_o.rst_clr_we)
    else $error("rst_clr_we longer than one cycle");

endmodule

bind tti_queue tti_sva u_sva (
  .clk_i,
  .rst_ni,
  .ctrl_i,
  .stat_o,
  .bus_valid_i,
  .bus_valid_o
);

//--- tb_clock.sv
`timescale 1ns/1ps
/* 20 ns clock, active-low reset held for the first ResetCycles rising edges */

module tb_clock #(
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- tti.sv
`timescale 1ns/1ps
/* RX queues take bus writes and CSR reads, TX and IBI queues take CSR writes and bus reads.
   Start thresholds are not supported */
`include "tti_settings.svh"

module tti (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  tti_csr_pkg::csr_tti_out_t csr_i,
  output tti_csr_pkg::csr_tti_in_t  csr_o,
  input  logic                      rx_desc_wvalid_i,
  input  tti_queue_pkg::rx_desc_t   rx_desc_wdata_i,
  output logic                      rx_desc_wready_o,
  input  logic                      rx_data_wvalid_i,
  input  tti_queue_pkg::data_word_t rx_data_wdata_i,
  output logic                      rx_data_wready_o,
  output logic                      tx_desc_rvalid_o,
  input  logic                      tx_desc_rready_i,
  output tti_queue_pkg::tx_desc_t   tx_desc_rdata_o,
  output logic                      tx_data_rvalid_o,
  input  logic                      tx_data_rready_i,
  output tti_queue_pkg::data_word_t tx_data_rdata_o,
  output logic                      ibi_rvalid_o,
  input  logic                      ibi_rready_i,
  output tti_queue_pkg::data_word_t ibi_rdata_o
);

  tti_queue_pkg::queue_ctrl_t ctrl [5];
  tti_queue_pkg::queue_stat_t stat [5];  // Index matches interrupt bit pairs

  tti_csr_port u_csr_port (
    .clk_i, .rst_ni, .csr_i,
    .rx_desc_ctrl_o(ctrl[0]), .rx_data_ctrl_o(ctrl[1]), .tx_desc_ctrl_o(ctrl[2]),
    .tx_data_ctrl_o(ctrl[3]), .ibi_ctrl_o(ctrl[4])
  );

  tti_queue #(
    .T(tti_queue_pkg::rx_desc_t), .Depth(`TTI_DESC_DEPTH), .CsrWrites(1'b0)
  ) u_rx_desc (
    .clk_i, .rst_ni, .ctrl_i(ctrl[0]), .stat_o(stat[0]),
    .bus_valid_i(rx_desc_wvalid_i), .bus_data_i(rx_desc_wdata_i), .bus_ready_i(1'b0),
    .bus_ready_o(rx_desc_wready_o), .bus_valid_o(), .bus_data_o()
  );

  tti_queue #(
    .T(tti_queue_pkg::data_word_t), .Depth(`TTI_DATA_DEPTH), .CsrWrites(1'b0)
  ) u_rx_data (
    .clk_i, .rst_ni, .ctrl_i(ctrl[1]), .stat_o(stat[1]),
    .bus_valid_i(rx_data_wvalid_i), .bus_data_i(rx_data_wdata_i), .bus_ready_i(1'b0),
    .bus_ready_o(rx_data_wready_o), .bus_valid_o(), .bus_data_o()
  );

  tti_queue #(
    .T(tti_queue_pkg::tx_desc_t), .Depth(`TTI_DESC_DEPTH), .CsrWrites(1'b1)
  ) u_tx_desc (
    .clk_i, .rst_ni, .ctrl_i(ctrl[2]), .stat_o(stat[2]),
    .bus_valid_i(1'b0), .bus_data_i('0), .bus_ready_i(tx_desc_rready_i),
    .bus_ready_o(), .bus_valid_o(tx_desc_rvalid_o), .bus_data_o(tx_desc_rdata_o)
  );

  tti_queue #(
    .T(tti_queue_pkg::data_word_t), .Depth(`TTI_DATA_DEPTH), .CsrWrites(1'b1)
  ) u_tx_data (
    .clk_i, .rst_ni, .ctrl_i(ctrl[3]), .stat_o(stat[3]),
    .bus_valid_i(1'b0), .bus_data_i('0), .bus_ready_i(tx_data_rready_i),
    .bus_ready_o(), .bus_valid_o(tx_data_rvalid_o), .bus_data_o(tx_data_rdata_o)
  );

  tti_queue #(
    .T(tti_queue_pkg::data_word_t), .Depth(`TTI_IBI_DEPTH), .CsrWrites(1'b1)
  ) u_ibi (
    .clk_i, .rst_ni, .ctrl_i(ctrl[4]), .stat_o(stat[4]),
    .bus_valid_i(1'b0), .bus_data_i('0), .bus_ready_i(ibi_rready_i),
    .bus_ready_o(), .bus_valid_o(ibi_rvalid_o), .bus_data_o(ibi_rdata_o)
  );

  tti_irq_status u_irq_status (
    .clk_i, .rst_ni, .stat_i(stat),
    .w1c_i(csr_i.irq_w1c), .enable_i(csr_i.irq_enable),
    .status_o(csr_o.irq_status), .irq_o(csr_o.irq)
  );

  assign csr_o.rx_desc_stat = stat[0];
  assign csr_o.rx_data_stat = stat[1];
  assign csr_o.tx_desc_stat = stat[2];
  assign csr_o.tx_data_stat = stat[3];
  assign csr_o.ibi_stat     = stat[4];

endmodule

//--- tti_irq_status.sv
`timescale 1ns/1ps
/* Bit 2q flags a rising trigger of queue q, bit 2q+1 its overflow or underflow.
   A set in the same cycle as a W1C wins */
`include "tti_settings.svh"

module tti_irq_status (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  tti_queue_pkg::queue_stat_t stat_i [`TTI_IRQ_N/2],
  input  logic [`TTI_IRQ_N-1:0]      w1c_i,
  input  logic [`TTI_IRQ_N-1:0]      enable_i,
  output logic [`TTI_IRQ_N-1:0]      status_o,
  output logic                       irq_o
);

  localparam int unsigned NumQueues = `TTI_IRQ_N / 2;

  logic [NumQueues-1:0]  trig;
  logic [NumQueues-1:0]  trig_q;
  logic [`TTI_IRQ_N-1:0] set;
  logic [`TTI_IRQ_N-1:0] status_q;
  logic                  irq_q;

  always_comb begin
    for (int q = 0; q < NumQueues; q++) begin
      trig[q]      = stat_i[q].ready_trig;
      set[2*q]     = stat_i[q].ready_trig & ~trig_q[q];  // Rising edge only
      set[2*q + 1] = stat_i[q].overflow | stat_i[q].underflow;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trig_q   <= '0;
      status_q <= '0;
      irq_q    <= 1'b0;
    end else begin
      trig_q   <= trig;
      status_q <= (status_q & ~w1c_i) | set;
      irq_q    <= |(status_q & enable_i);
    end
  end

  assign status_o = status_q;
  assign irq_o    = irq_q;

endmodule

//--- tti_queue.sv
`timescale 1ns/1ps
/* T must be packed and at most 32 bits. Depth at least 2 and within the threshold range.
   CsrWrites=0 gives a bus-written, CSR-read queue; CsrWrites=1 the reverse */
`include "tti_settings.svh"

module tti_queue #(
  parameter type         T         = logic [31:0],
  parameter int unsigned Depth     = 8,
  parameter bit          CsrWrites = 1'b0
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  tti_queue_pkg::queue_ctrl_t ctrl_i,
  input  logic                       bus_valid_i,
  input  logic                       bus_ready_i,
  input  T                           bus_data_i,
  output logic                       bus_valid_o,
  output logic                       bus_ready_o,
  output T                           bus_data_o,
  output tti_queue_pkg::queue_stat_t stat_o
);

  localparam int unsigned AddrW = $clog2(Depth);
  localparam int unsigned CntW  = $clog2(Depth + 1);
  localparam int unsigned ThldW = `TTI_THLD_W;

  T                    mem_q [Depth];
  logic [AddrW-1:0]    wr_ptr_q;
  logic [AddrW-1:0]    rd_ptr_q;
  logic [CntW-1:0]     count_q;
  logic                full;
  logic                empty;
  logic                push;
  logic                pop;
  T                    push_data;
  logic [$bits(T)-1:0] head_bits;
  logic [ThldW-1:0]    thld_q;
  logic [ThldW-1:0]    fill;
  logic [ThldW-1:0]    space;
  logic                trig;
  logic                ack_q;
  logic                ovf_q;
  logic                udf_q;
  logic [31:0]         rd_data_q;
  logic                rst_seen_q;
  logic                rst_clr_q;

  function automatic logic [AddrW-1:0] ptr_inc(input logic [AddrW-1:0] ptr);
    return (ptr == AddrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty = (count_q == '0);
  assign full  = (count_q == CntW'(Depth));

  assign bus_valid_o = ~empty;
  assign bus_ready_o = ~full;  // Combinational wready
  assign bus_data_o  = mem_q[rd_ptr_q];
  assign head_bits   = bus_data_o;

  always_comb begin
    if (CsrWrites) begin
      push      = ctrl_i.req & ~full;
      pop       = bus_ready_i & ~empty;
      push_data = T'(ctrl_i.wr_data[$bits(T)-1:0]);
    end else begin
      push      = bus_valid_i & ~full;
      pop       = ctrl_i.req & ~empty;
      push_data = bus_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (ctrl_i.soft_rst) begin  // Flush on every edge while held
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push && !ctrl_i.soft_rst) mem_q[wr_ptr_q] <= push_data;
  end

  // CSR side responds in the cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q      <= 1'b0;
      ovf_q      <= 1'b0;
      udf_q      <= 1'b0;
      rd_data_q  <= '0;
      thld_q     <= '0;
      rst_seen_q <= 1'b0;
      rst_clr_q  <= 1'b0;
    end else begin
      ack_q <= ctrl_i.req;
      ovf_q <= CsrWrites & ctrl_i.req & full;
      udf_q <= ~CsrWrites & ctrl_i.req & empty;
      if (ctrl_i.req) rd_data_q <= (CsrWrites || empty) ? '0 : 32'(head_bits);
      if (ctrl_i.thld_we) begin
        thld_q <= (ctrl_i.ready_thld > ThldW'(Depth)) ? ThldW'(Depth) : ctrl_i.ready_thld;
      end
      rst_seen_q <= ctrl_i.soft_rst;
      rst_clr_q  <= ctrl_i.soft_rst & ~rst_seen_q;  // One shot per reset request
    end
  end

  // RX compares fill level, TX and IBI compare free space
  assign fill  = ThldW'(count_q);
  assign space = ThldW'(Depth) - fill;
  assign trig  = (thld_q != '0) && ((CsrWrites ? space : fill) >= thld_q);

  always_comb begin
    stat_o.full           = full;
    stat_o.empty          = empty;
    stat_o.ready_trig     = trig;
    stat_o.overflow       = ovf_q;
    stat_o.underflow      = udf_q;
    stat_o.ack            = ack_q;
    stat_o.rd_data        = rd_data_q;
    stat_o.ready_thld_eff = thld_q;
    stat_o.rst_clr_we     = rst_clr_q;
  end

endmodule

//--- tti_csr_port.sv
`timescale 1ns/1ps
/* RX ports only honor reads, TX and IBI ports only writes.
   Threshold values must hold for two cycles after swmod */
`include "tti_settings.svh"

module tti_csr_port (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  tti_csr_pkg::csr_tti_out_t  csr_i,
  output tti_queue_pkg::queue_ctrl_t rx_desc_ctrl_o,
  output tti_queue_pkg::queue_ctrl_t rx_data_ctrl_o,
  output tti_queue_pkg::queue_ctrl_t tx_desc_ctrl_o,
  output tti_queue_pkg::queue_ctrl_t tx_data_ctrl_o,
  output tti_queue_pkg::queue_ctrl_t ibi_ctrl_o
);

  logic [4:0] swmod_q;    // Queue order rx_desc, rx_data, tx_desc, tx_data, ibi
  logic [4:0] thld_we_q;

  function automatic tti_queue_pkg::queue_ctrl_t build_ctrl(
    input tti_csr_pkg::csr_port_t port,
    input logic                   csr_writes,
    input logic [`TTI_THLD_W-1:0] thld,
    input logic                   thld_we,
    input logic                   soft_rst
  );
    tti_queue_pkg::queue_ctrl_t ctrl;
    ctrl.req        = port.req & (port.req_is_wr == csr_writes);
    ctrl.wr_data    = port.wr_data;
    ctrl.ready_thld = thld;
    ctrl.thld_we    = thld_we;
    ctrl.soft_rst   = soft_rst;
    return ctrl;
  endfunction

  // Write enable trails swmod by two cycles
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      swmod_q   <= '0;
      thld_we_q <= '0;
    end else begin
      swmod_q   <= {csr_i.ibi_thld.swmod,
                    csr_i.tx_data_thld.swmod,
                    csr_i.tx_desc_thld.swmod,
                    csr_i.rx_data_thld.swmod,
                    csr_i.rx_desc_thld.swmod};
      thld_we_q <= swmod_q;
    end
  end

  assign rx_desc_ctrl_o = build_ctrl(csr_i.rx_desc_port, 1'b0, csr_i.rx_desc_thld.value,
                                     thld_we_q[0], csr_i.rx_desc_rst);
  assign rx_data_ctrl_o = build_ctrl(csr_i.rx_data_port, 1'b0, csr_i.rx_data_thld.value,
                                     thld_we_q[1], csr_i.rx_data_rst);
  assign tx_desc_ctrl_o = build_ctrl(csr_i.tx_desc_port, 1'b1, csr_i.tx_desc_thld.value,
                                     thld_we_q[2], csr_i.tx_desc_rst);
  assign tx_data_ctrl_o = build_ctrl(csr_i.tx_data_port, 1'b1, csr_i.tx_data_thld.value,
                                     thld_we_q[3], csr_i.tx_data_rst);
  assign ibi_ctrl_o     = build_ctrl(csr_i.ibi_port, 1'b1, csr_i.ibi_thld.value,
                                     thld_we_q[4], csr_i.ibi_rst);

endmodule

//--- tti_csr_pkg.sv
/* Register file view of the transaction interface. Requires tti_queue_pkg compiled first */
`include "tti_settings.svh"

package tti_csr_pkg;

  typedef struct packed {
    logic        req;
    logic        req_is_wr;
    logic [31:0] wr_data;
  } csr_port_t;

  typedef struct packed {
    logic [`TTI_THLD_W-1:0] value;
    logic                   swmod;  // Pulses on software write
  } csr_thld_t;

  typedef struct packed {
    csr_port_t             rx_desc_port;
    csr_port_t             rx_data_port;
    csr_port_t             tx_desc_port;
    csr_port_t             tx_data_port;
    csr_port_t             ibi_port;
    csr_thld_t             rx_desc_thld;
    csr_thld_t             rx_data_thld;
    csr_thld_t             tx_desc_thld;
    csr_thld_t             tx_data_thld;
    csr_thld_t             ibi_thld;
    logic                  rx_desc_rst;
    logic                  rx_data_rst;
    logic                  tx_desc_rst;
    logic                  tx_data_rst;
    logic                  ibi_rst;
    logic [`TTI_IRQ_N-1:0] irq_w1c;
    logic [`TTI_IRQ_N-1:0] irq_enable;
  } csr_tti_out_t;

  // Status bit 2q is the trigger of queue q, 2q+1 its overflow or underflow
  typedef struct packed {
    tti_queue_pkg::queue_stat_t rx_desc_stat;
    tti_queue_pkg::queue_stat_t rx_data_stat;
    tti_queue_pkg::queue_stat_t tx_desc_stat;
    tti_queue_pkg::queue_stat_t tx_data_stat;
    tti_queue_pkg::queue_stat_t ibi_stat;
    logic [`TTI_IRQ_N-1:0]      irq_status;
    logic                       irq;
  } csr_tti_in_t;

endpackage

//--- tti_queue_pkg.sv
/* Queue payloads and the control and status exchanged with each queue.
   Payload types must stay within one 32-bit CSR word */
`include "tti_settings.svh"

package tti_queue_pkg;

  // Received-transfer descriptor
  typedef struct packed {
    logic [3:0]  rsvd;
    logic [3:0]  err;
    logic [7:0]  cmd;
    logic [15:0] data_len;
  } rx_desc_t;

  // Transmit descriptor
  typedef struct packed {
    logic [7:0]  rsvd;
    logic [7:0]  tag;
    logic [15:0] data_len;
  } tx_desc_t;

  typedef logic [31:0] data_word_t;  // Also used for IBI entries

  typedef struct packed {
    logic                   req;       // Already qualified by direction
    logic [31:0]            wr_data;
    logic [`TTI_THLD_W-1:0] ready_thld;
    logic                   thld_we;
    logic                   soft_rst;
  } queue_ctrl_t;

  typedef struct packed {
    logic                   full;
    logic                   empty;
    logic                   ready_trig;
    logic                   overflow;
    logic                   underflow;
    logic                   ack;
    logic [31:0]            rd_data;
    logic [`TTI_THLD_W-1:0] ready_thld_eff;
    logic                   rst_clr_we;  // Clears CSR reset bit
  } queue_stat_t;

endpackage

//--- tti_settings.svh
/* Queue depths must be at least 2 and no larger than 2**TTI_THLD_W - 1.
   TTI_IRQ_N is two bits per queue, five queues */
`ifndef TTI_SETTINGS_SVH
`define TTI_SETTINGS_SVH

// Descriptor queues, RX and TX
`define TTI_DESC_DEPTH 8

// Data queues, RX and TX
`define TTI_DATA_DEPTH 16

`define TTI_IBI_DEPTH 4

// Shared by every ready threshold
`define TTI_THLD_W 5

// Trigger and error bit per queue
`define TTI_IRQ_N 10

`endif
